// ==== rsa_avm_top.f ====
rtl/rsa_pkg.sv
rtl/avm_pkg.sv
rtl/rsa_mod_prod.sv
rtl/rsa_mont.sv
rtl/rsa_core.sv
rtl/rsa_avm_wrapper.sv
rtl/rsa_avm_top.sv
bench/rsa_avm_tb.sv

// ==== bench/rsa_avm_tb.sv ====
`default_nettype none

module rsa_avm_tb
    import rsa_pkg::*;
    import avm_pkg::*;
();

    localparam int wait_limit = 400000;
    localparam int num_blocks = 5;

    logic        avm_clk = 1'b0;
    logic        avm_rst;
    avm_addr_t   avm_address;
    logic        avm_read;
    logic        avm_write;
    logic [31:0] avm_writedata;
    logic [31:0] avm_readdata;
    logic        avm_waitrequest;

    logic [31:0] lfsr_state = 32'h3a58ce66;

    // serial port model state
    logic [7:0]  send_q[$];
    logic [7:0]  out_q[$];
    avm_cmd_t    prev_cmd;
    logic        held;
    logic [31:0] offered_status;
    logic [31:0] last_status;

    rsa_avm_top dut_i (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_readdata    (avm_readdata),
        .avm_waitrequest (avm_waitrequest)
    );

    always #20 avm_clk = ~avm_clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(input string name, input rsa_word_t got, input rsa_word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_cmd(input string name, input avm_cmd_t got, input avm_cmd_t exp);
        if (got !== exp) begin
            abort_run($sformatf({"mismatch at %0t: %s got addr %h rd %b wr %b data %h, ",
                                 "expected addr %h rd %b wr %b data %h"},
                                $time, name, got.address, got.read, got.write, got.writedata,
                                exp.address, exp.read, exp.write, exp.writedata));
        end
    endtask

    // galois lfsr with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic next_rand_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int width);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < width; i++) begin
            r = {r[30:0], next_rand_bit()};
        end
        return r;
    endfunction

    function automatic rsa_word_t rand_word();
        rsa_word_t w;
        w = '0;
        for (int i = 0; i < rsa_bits; i++) begin
            w = {w[rsa_bits-2:0], next_rand_bit()};
        end
        return w;
    endfunction

    // reference square and multiply with double width products
    function automatic rsa_word_t mod_exp(input rsa_word_t base, input rsa_word_t e,
                                          input rsa_word_t m);
        logic [2*rsa_bits-1:0] r;
        logic [2*rsa_bits-1:0] b;
        logic [2*rsa_bits-1:0] mw;
        r  = 1;
        b  = base;
        mw = m;
        for (int i = 0; i < rsa_bits; i++) begin
            if (e[i]) begin
                r = (r * b) % mw;
            end
            b = (b * b) % mw;
        end
        return r[rsa_bits-1:0];
    endfunction

    function automatic avm_cmd_t read_bus_cmd();
        avm_cmd_t c;
        c.address   = avm_address;
        c.read      = avm_read;
        c.write     = avm_write;
        c.writedata = avm_writedata;
        return c;
    endfunction

    function automatic rsa_word_t result_from_bytes();
        rsa_word_t w;
        w = '0;
        foreach (out_q[i]) begin
            w = (w << 8) | rsa_word_t'(out_q[i]);
        end
        return w;
    endfunction

    // the slave offers data for a command it has seen held under waitrequest
    task automatic release_transfer(input avm_cmd_t cur);
        avm_waitrequest <= 1'b0;
        if (cur.read) begin
            if (cur.address == status_base) begin
                offered_status = '0;
                offered_status[rx_ok_bit] = (send_q.size() != 0) && next_rand_bit();
                offered_status[tx_ok_bit] = (rand_bits(2) != 0);
                avm_readdata <= offered_status;
            end else if (cur.address == rx_base) begin
                if (send_q.size() == 0) begin
                    abort_run("receive register read while no byte is waiting");
                end
                avm_readdata <= {24'd0, send_q[0]};
            end else begin
                abort_run($sformatf("read from unmapped register address %h", cur.address));
            end
        end
    endtask

    task automatic complete_transfer(input avm_cmd_t cur);
        avm_waitrequest <= 1'b1;
        avm_readdata    <= rand_bits(32);
        if (cur.read && cur.address == status_base) begin
            last_status = offered_status;
        end else if (cur.read) begin
            if (!last_status[rx_ok_bit]) begin
                abort_run("receive register read without a ready status answer");
            end
            void'(send_q.pop_front());
            last_status = '0;
        end else begin
            if (cur.address != tx_base) begin
                abort_run($sformatf("write to register address %h", cur.address));
            end
            if (!last_status[tx_ok_bit]) begin
                abort_run("transmit register written without a ready status answer");
            end
            if (send_q.size() != 0) begin
                abort_run("result byte written before all operand bytes were read");
            end
            if (out_q.size() >= rsa_out_bytes) begin
                abort_run("extra write after the last result byte");
            end
            out_q.push_back(cur.writedata[7:0]);
            last_status = '0;
        end
    endtask

    task automatic serve_bus_edge();
        avm_cmd_t cur;
        cur = read_bus_cmd();
        if (cur.read && cur.write) begin
            abort_run("read and write strobes high together");
        end
        if (held) begin
            check_cmd("bus command under waitrequest", cur, prev_cmd);
        end
        held     = (cur.read || cur.write) && avm_waitrequest;
        prev_cmd = cur;
        if (cur.read || cur.write) begin
            if (avm_waitrequest) begin
                if (rand_bits(2) != 0) begin
                    release_transfer(cur);
                end
            end else begin
                complete_transfer(cur);
            end
        end
    endtask

    initial begin
        avm_waitrequest = 1'b1;
        avm_readdata    = '0;
        held            = 1'b0;
        offered_status  = '0;
        last_status     = '0;
        forever begin
            @(posedge avm_clk);
            if (avm_rst) begin
                held        = 1'b0;
                last_status = '0;
                avm_waitrequest <= 1'b1;
            end else begin
                serve_bus_edge();
            end
        end
    end

    task automatic queue_word(input rsa_word_t w);
        for (int i = rsa_bytes - 1; i >= 0; i--) begin
            send_q.push_back(w[8*i +: 8]);
        end
    endtask

    task automatic wait_operands_read();
        int cycles;
        cycles = 0;
        while (send_q.size() != 0) begin
            if (cycles >= wait_limit) begin
                abort_run("timeout waiting for the operand bytes to be read");
            end
            @(negedge avm_clk);
            cycles++;
        end
    endtask

    task automatic wait_result_bytes();
        int cycles;
        cycles = 0;
        while (out_q.size() < rsa_out_bytes) begin
            if (cycles >= wait_limit) begin
                abort_run("timeout waiting for the result bytes");
            end
            @(negedge avm_clk);
            cycles++;
        end
    endtask

    initial begin
        rsa_word_t n;
        rsa_word_t d;
        rsa_word_t a;
        rsa_word_t expected;
        rsa_word_t got;
        avm_cmd_t  reset_exp;
        avm_cmd_t  reset_got;
        avm_rst = 1'b1;
        repeat (8) @(posedge avm_clk);
        avm_rst <= 1'b0;
        @(negedge avm_clk);
        reset_got = read_bus_cmd();
        reset_exp = reset_got;
        reset_exp.address = status_base;
        reset_exp.read    = 1'b1;
        reset_exp.write   = 1'b0;
        check_cmd("bus command after reset", reset_got, reset_exp);
        for (int blk = 0; blk < num_blocks; blk++) begin
            // odd modulus with bit 254 set keeps it above any 254-bit value
            n = rand_word();
            n[rsa_bits-1] = 1'b0;
            n[rsa_bits-2] = 1'b1;
            n[0]          = 1'b1;
            d = rand_word();
            a = rand_word();
            a[rsa_bits-1] = 1'b0;
            if (a >= n) begin
                a = a - n;
            end
            expected = mod_exp(a, d, n);
            expected[rsa_bits-1 -: 8*(rsa_bytes-rsa_out_bytes)] = '0;
            queue_word(n);
            queue_word(d);
            queue_word(a);
            wait_operands_read();
            wait_result_bytes();
            got = result_from_bytes();
            out_q.delete();
            check_word("result", got, expected);
            $display("block %0d done, result %h", blk, got);
        end
        // idle polling only after the last block
        repeat (200) @(negedge avm_clk);
        if (out_q.size() != 0) begin
            abort_run("write seen after the last block");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rsa_avm_top.sv ====
`default_nettype none

module rsa_avm_top
    import rsa_pkg::*;
    import avm_pkg::*;
(
    input  logic        avm_clk,
    input  logic        avm_rst,
    output avm_addr_t   avm_address,
    output logic        avm_read,
    output logic        avm_write,
    output logic [31:0] avm_writedata,
    input  logic [31:0] avm_readdata,
    input  logic        avm_waitrequest
);

    avm_cmd_t  cmd;
    rsa_req_t  rsa_req;
    logic      rsa_start;
    logic      finished;
    rsa_word_t result;

    rsa_avm_wrapper wrapper_i (
        .avm_clk     (avm_clk),
        .avm_rst     (avm_rst),
        .cmd         (cmd),
        .readdata    (avm_readdata),
        .waitrequest (avm_waitrequest),
        .rsa_req     (rsa_req),
        .rsa_start   (rsa_start),
        .finished    (finished),
        .result      (result)
    );

    rsa_core core_i (
        .avm_clk  (avm_clk),
        .avm_rst  (avm_rst),
        .start    (rsa_start),
        .req      (rsa_req),
        .finished (finished),
        .result   (result)
    );

    assign avm_address   = cmd.address;
    assign avm_read      = cmd.read;
    assign avm_write     = cmd.write;
    assign avm_writedata = cmd.writedata;

endmodule

`default_nettype wire

// ==== rtl/rsa_avm_wrapper.sv ====
`default_nettype none

module rsa_avm_wrapper
    import rsa_pkg::*;
    import avm_pkg::*;
(
    input  logic        avm_clk,
    input  logic        avm_rst,
    output avm_cmd_t    cmd,
    input  logic [31:0] readdata,
    input  logic        waitrequest,
    output rsa_req_t    rsa_req,
    output logic        rsa_start,
    input  logic        finished,
    input  rsa_word_t   result
);

    typedef enum logic [2:0] {
        s_rx_poll,
        s_rx_read,
        s_calc,
        s_load,
        s_tx_poll,
        s_tx_write
    } state_t;

    // n, d and a arrive back to back with 32 bytes each
    localparam int last_in_byte  = 3 * rsa_bytes - 1;
    localparam int last_out_byte = rsa_out_bytes - 1;

    state_t     state;
    logic [6:0] byte_cnt;
    logic       xfer_done;
    rsa_word_t  n_r;
    rsa_word_t  d_r;
    rsa_word_t  a_r;
    rsa_word_t  out_r;

    function automatic avm_cmd_t bus_read(input avm_addr_t addr);
        avm_cmd_t c;
        c           = '0;
        c.address   = addr;
        c.read      = 1'b1;
        return c;
    endfunction

    function automatic avm_cmd_t bus_write(input avm_addr_t addr, input logic [7:0] data);
        avm_cmd_t c;
        c           = '0;
        c.address   = addr;
        c.write     = 1'b1;
        c.writedata = {24'd0, data};
        return c;
    endfunction

    // every state that waits on the bus has a strobe up
    assign xfer_done = !waitrequest;

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state     <= s_rx_poll;
            byte_cnt  <= '0;
            cmd       <= bus_read(status_base);
            rsa_start <= 1'b0;
        end else begin
            rsa_start <= 1'b0;
            case (state)
                s_rx_poll: begin
                    if (xfer_done && readdata[rx_ok_bit]) begin
                        cmd   <= bus_read(rx_base);
                        state <= s_rx_read;
                    end
                end
                s_rx_read: begin
                    if (xfer_done) begin
                        if (byte_cnt == 7'(last_in_byte)) begin
                            cmd       <= '0;
                            byte_cnt  <= '0;
                            rsa_start <= 1'b1;
                            state     <= s_calc;
                        end else begin
                            byte_cnt <= byte_cnt + 7'd1;
                            cmd      <= bus_read(status_base);
                            state    <= s_rx_poll;
                        end
                    end
                end
                s_calc: begin
                    if (finished) begin
                        state <= s_load;
                    end
                end
                s_load: begin
                    cmd   <= bus_read(status_base);
                    state <= s_tx_poll;
                end
                s_tx_poll: begin
                    if (xfer_done && readdata[tx_ok_bit]) begin
                        cmd   <= bus_write(tx_base, out_r[8*rsa_out_bytes-1 -: 8]);
                        state <= s_tx_write;
                    end
                end
                default: begin
                    if (xfer_done) begin
                        cmd <= bus_read(status_base);
                        if (byte_cnt == 7'(last_out_byte)) begin
                            byte_cnt <= '0;
                            state    <= s_rx_poll;
                        end else begin
                            byte_cnt <= byte_cnt + 7'd1;
                            state    <= s_tx_poll;
                        end
                    end
                end
            endcase
        end
    end

    // first byte received ends up most significant
    always_ff @(posedge avm_clk) begin
        if (state == s_rx_read && xfer_done) begin
            case (byte_cnt[6:5])
                2'd0:    n_r <= {n_r[rsa_bits-9:0], readdata[7:0]};
                2'd1:    d_r <= {d_r[rsa_bits-9:0], readdata[7:0]};
                default: a_r <= {a_r[rsa_bits-9:0], readdata[7:0]};
            endcase
        end
        if (state == s_load) begin
            out_r <= result;
        end else if (state == s_tx_write && xfer_done) begin
            out_r <= out_r << 8;
        end
    end

    assign rsa_req.a = a_r;
    assign rsa_req.d = d_r;
    assign rsa_req.n = n_r;

endmodule

`default_nettype wire

// ==== rtl/rsa_core.sv ====
`default_nettype none

module rsa_core
    import rsa_pkg::*;
(
    input  logic      avm_clk,
    input  logic      avm_rst,
    input  logic      start,
    input  rsa_req_t  req,
    output logic      finished,
    output rsa_word_t result
);

    typedef enum logic [1:0] {
        s_idle,
        s_prep,
        s_loop
    } state_t;

    state_t    state;
    logic [7:0] bit_cnt;
    logic      mp_start;
    logic      mp_done;
    rsa_word_t mp_res;
    logic      mont_start;
    logic      mul_done;
    rsa_word_t mul_res;
    logic      sq_done;
    rsa_word_t sq_res;
    rsa_word_t prod;
    rsa_word_t sq;

    // a * 2^256 mod n brings a into Montgomery form
    rsa_mod_prod mod_prod_i (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (mp_start),
        .a       (req.a),
        .n       (req.n),
        .done    (mp_done),
        .result  (mp_res)
    );

    // multiply step keeps the product a plain residue
    rsa_mont mul_i (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (mont_start),
        .a       (prod),
        .b       (sq),
        .n       (req.n),
        .done    (mul_done),
        .result  (mul_res)
    );

    rsa_mont sq_i (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (mont_start),
        .a       (sq),
        .b       (sq),
        .n       (req.n),
        .done    (sq_done),
        .result  (sq_res)
    );

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state      <= s_idle;
            bit_cnt    <= '0;
            mp_start   <= 1'b0;
            mont_start <= 1'b0;
            finished   <= 1'b0;
        end else begin
            mp_start   <= 1'b0;
            mont_start <= 1'b0;
            finished   <= 1'b0;
            case (state)
                s_idle: begin
                    if (start) begin
                        mp_start <= 1'b1;
                        state    <= s_prep;
                    end
                end
                s_prep: begin
                    if (mp_done) begin
                        bit_cnt    <= '0;
                        mont_start <= 1'b1;
                        state      <= s_loop;
                    end
                end
                default: begin
                    if (sq_done) begin
                        bit_cnt <= bit_cnt + 8'd1;
                        if (bit_cnt == 8'(rsa_bits - 1)) begin
                            finished <= 1'b1;
                            state    <= s_idle;
                        end else begin
                            mont_start <= 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // exponent scanned lsb first
    always_ff @(posedge avm_clk) begin
        if (state == s_prep && mp_done) begin
            sq   <= mp_res;
            prod <= rsa_word_t'(1);
        end
        if (state == s_loop && sq_done) begin
            sq <= sq_res;
            if (mul_done && req.d[bit_cnt]) begin
                prod <= mul_res;
            end
        end
    end

    assign result = prod;

endmodule

`default_nettype wire

// ==== rtl/rsa_mont.sv ====
`default_nettype none

module rsa_mont
    import rsa_pkg::*;
(
    input  logic      avm_clk,
    input  logic      avm_rst,
    input  logic      start,
    input  rsa_word_t a,
    input  rsa_word_t b,
    input  rsa_word_t n,
    output logic      done,
    output rsa_word_t result
);

    // m stays below 2n through the loop
    logic [rsa_bits:0]   m;
    logic [rsa_bits+1:0] sum;
    logic [rsa_bits+1:0] sum_n;
    rsa_word_t           a_sh;
    logic [8:0]          cnt;
    logic                busy;
    logic                last_step;

    always_comb begin
        sum = {1'b0, m};
        if (a_sh[0]) begin
            sum = sum + {2'b00, b};
        end
        // make the sum even before halving
        sum_n = sum;
        if (sum[0]) begin
            sum_n = sum + {2'b00, n};
        end
    end

    assign last_step = (cnt == 9'(rsa_bits));

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 9'd1;
                if (last_step) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge avm_clk) begin
        if (start) begin
            m    <= '0;
            a_sh <= a;
        end else if (busy && !last_step) begin
            m    <= sum_n[rsa_bits+1:1];
            a_sh <= a_sh >> 1;
        end else if (busy && m >= {1'b0, n}) begin
            // final correction into [0, n)
            m <= m - {1'b0, n};
        end
    end

    assign result = m[rsa_bits-1:0];

endmodule

`default_nettype wire

// ==== rtl/rsa_mod_prod.sv ====
`default_nettype none

module rsa_mod_prod
    import rsa_pkg::*;
(
    input  logic      avm_clk,
    input  logic      avm_rst,
    input  logic      start,
    input  rsa_word_t a,
    input  rsa_word_t n,
    output logic      done,
    output rsa_word_t result
);

    rsa_word_t       acc;
    logic [rsa_bits:0] acc_dbl;
    logic [rsa_bits:0] acc_red;
    logic [7:0]      cnt;
    logic            busy;

    // acc stays below n, so one subtraction after doubling is enough
    always_comb begin
        acc_dbl = {acc, 1'b0};
        if (acc_dbl >= {1'b0, n}) begin
            acc_red = acc_dbl - {1'b0, n};
        end else begin
            acc_red = acc_dbl;
        end
    end

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 8'd1;
                if (cnt == 8'(rsa_bits - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge avm_clk) begin
        if (start) begin
            acc <= a;
        end else if (busy) begin
            acc <= acc_red[rsa_bits-1:0];
        end
    end

    assign result = acc;

endmodule

`default_nettype wire

// ==== rtl/avm_pkg.sv ====
`default_nettype none

package avm_pkg;

    typedef logic [4:0] avm_addr_t;

    // register map of the serial port
    localparam avm_addr_t rx_base     = 5'd0;
    localparam avm_addr_t tx_base     = 5'd4;
    localparam avm_addr_t status_base = 5'd8;

    // status register bits
    localparam int tx_ok_bit = 6;
    localparam int rx_ok_bit = 7;

    // one master request with the data byte in writedata[7:0]
    typedef struct packed {
        avm_addr_t   address;
        logic        read;
        logic        write;
        logic [31:0] writedata;
    } avm_cmd_t;

endpackage

`default_nettype wire

// ==== rtl/rsa_pkg.sv ====
`default_nettype none

package rsa_pkg;

    // the byte protocol fixes the key size
    localparam int rsa_bits      = 256;
    localparam int rsa_bytes     = rsa_bits / 8;
    // only the low 31 bytes go back to the host
    localparam int rsa_out_bytes = 31;

    typedef logic [rsa_bits-1:0] rsa_word_t;

    // operand set of one exponentiation held from start to finished
    typedef struct packed {
        rsa_word_t a;
        rsa_word_t d;
        rsa_word_t n;
    } rsa_req_t;

endpackage

`default_nettype wire
